/* logic/video_pkg.sv */
// shared timing constants, CPU port addresses, slot numbers and types for the video controller

package video_pkg;

	// ------------------------------------------------------------
	// 1280x720 timing
	// ------------------------------------------------------------
	typedef logic [11:0] t_count;

	// horizontal, in clocks
	localparam t_count h_total  = 12'd1650;
	localparam t_count h_sync   = 12'd40;
	localparam t_count h_bporch = 12'd220;
	localparam t_count h_res    = 12'd1280;

	// vertical, in lines
	localparam t_count v_total  = 12'd750;
	localparam t_count v_sync   = 12'd5;
	localparam t_count v_bporch = 12'd20;
	localparam t_count v_res    = 12'd720;

	// ------------------------------------------------------------
	// CPU I/O ports
	// ------------------------------------------------------------
	localparam logic [7:0] port_palette_index = 8'h20;
	localparam logic [7:0] port_palette_data  = 8'h21;
	localparam logic [7:0] port_vram_address  = 8'h22;
	localparam logic [7:0] port_vram_data     = 8'h23;

	// ------------------------------------------------------------
	// SDRAM slot cycle
	// ------------------------------------------------------------
	// position in the 16-clock cycle, 0 on the first active clock
	typedef logic [3:0] t_slot;

	localparam t_slot slot_write      = 4'd7;
	localparam t_slot slot_write_done = 4'd8;
	localparam t_slot slot_read       = 4'd15;

	// ------------------------------------------------------------
	// data types
	// ------------------------------------------------------------
	typedef logic [22:0] t_vram_address;
	typedef logic [7:0]  t_pixel_index;
	typedef logic [9:0]  t_line_address;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} t_rgb;

endpackage

/* logic/sp_ram.sv */
// single-port synchronous RAM, read-first, payload chosen by a type parameter
`timescale 1ns/100ps

module sp_ram #(
	parameter type t_data = logic [7:0],
	parameter int  depth  = 256
) (
	input  logic                     clk,
	input  logic [$clog2(depth)-1:0] address,
	input  logic                     we,
	input  t_data                    wdata,
	output t_data                    rdata
);
	t_data mem [depth];

	// read returns the old word when written in the same clock
	always_ff @(posedge clk) begin
		if (we) begin
			mem[address] <= wdata;
		end
		rdata <= mem[address];
	end

endmodule

/* logic/cpu_registers.sv */
// CPU port decoder, holds palette and VRAM write requests until the slot schedule takes them
`timescale 1ns/100ps

module cpu_registers (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     iorq_n,
	input  logic [7:0]               address,
	input  logic                     wr_n,
	input  logic [7:0]               wdata,
	input  video_pkg::t_slot         slot,
	output logic                     palette_pending,
	output video_pkg::t_pixel_index  palette_index,
	output video_pkg::t_rgb          palette_rgb,
	output logic                     vram_write_pending,
	output video_pkg::t_vram_address vram_write_address,
	output logic [7:0]               vram_write_data
);
	logic                    iorq_n_q;
	logic                    wr_n_q;
	logic                    strobe;
	logic                    sel_index;
	logic                    sel_rgb;
	logic                    sel_vram_address;
	logic                    sel_vram_data;
	logic                    last_element;
	video_pkg::t_pixel_index index_counter;
	logic [1:0]              element;
	logic [1:0]              address_phase;

	// ------------------------------------------------------------
	// bus sampling
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			iorq_n_q <= 1'b1;
			wr_n_q   <= 1'b1;
		end else begin
			iorq_n_q <= iorq_n;
			wr_n_q   <= wr_n;
		end
	end

	// wr_n back high after a sampled I/O write
	assign strobe = !iorq_n_q && !wr_n_q && wr_n;

	assign sel_index        = strobe && address == video_pkg::port_palette_index;
	assign sel_rgb          = strobe && address == video_pkg::port_palette_data;
	assign sel_vram_address = strobe && address == video_pkg::port_vram_address;
	assign sel_vram_data    = strobe && address == video_pkg::port_vram_data;

	// blue byte completes an entry
	assign last_element = element == 2'd2;

	// ------------------------------------------------------------
	// palette
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			index_counter <= '0;
			element       <= 2'd0;
		end else if (sel_index) begin
			index_counter <= wdata;
			element       <= 2'd0;
		end else if (sel_rgb) begin
			if (last_element) begin
				// auto increment to the next entry
				index_counter <= index_counter + 8'd1;
				element       <= 2'd0;
			end else begin
				element <= element + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sel_rgb) begin
			case (element)
				2'd0:    palette_rgb.r <= wdata;
				2'd1:    palette_rgb.g <= wdata;
				default: palette_rgb.b <= wdata;
			endcase
			if (last_element) begin
				palette_index <= index_counter;
			end
		end
	end

	// taken by the palette on the next odd slot
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			palette_pending <= 1'b0;
		end else if (sel_rgb && last_element) begin
			palette_pending <= 1'b1;
		end else if (slot[0]) begin
			palette_pending <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// VRAM write
	// ------------------------------------------------------------
	// three address bytes, low first
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			vram_write_address <= '0;
			address_phase      <= 2'd0;
		end else if (vram_write_pending && slot == video_pkg::slot_write_done) begin
			// next data byte goes to the following address
			vram_write_address <= vram_write_address + 23'd1;
		end else if (sel_vram_address) begin
			case (address_phase)
				2'd0: begin
					vram_write_address[7:0] <= wdata;
					address_phase           <= 2'd1;
				end
				2'd1: begin
					vram_write_address[15:8] <= wdata;
					address_phase            <= 2'd2;
				end
				default: begin
					vram_write_address[22:16] <= wdata[6:0];
					address_phase             <= 2'd0;
				end
			endcase
		end
	end

	// a new byte wins over the done slot, no back-pressure
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			vram_write_pending <= 1'b0;
		end else if (sel_vram_data) begin
			vram_write_pending <= 1'b1;
		end else if (slot == video_pkg::slot_write_done) begin
			vram_write_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (sel_vram_data) begin
			vram_write_data <= wdata;
		end
	end

	a_address_phase : assert property (
		@(posedge clk) disable iff (!reset_n) address_phase != 2'd3
	);

endmodule

/* logic/display_timing.sv */
// 720p counters, active windows, syncs and the SDRAM slot position for every consumer
`timescale 1ns/100ps

module display_timing (
	input  logic              clk,
	input  logic              reset_n,
	output video_pkg::t_slot  slot,
	output logic              line_end,
	output video_pkg::t_count line,
	output logic              h_window,
	output logic              v_window,
	output logic              video_hs,
	output logic              video_vs
);
	video_pkg::t_count h_count;
	video_pkg::t_count h_offset;
	logic              frame_end;

	assign line_end  = h_count == video_pkg::h_total - 12'd1;
	assign frame_end = line == video_pkg::v_total - 12'd1;

	// slot 0 is the first active clock
	assign h_offset = h_count - (video_pkg::h_sync + video_pkg::h_bporch);
	assign slot     = h_offset[3:0];

	// ------------------------------------------------------------
	// counters
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			h_count <= '0;
		end else if (line_end) begin
			h_count <= '0;
		end else begin
			h_count <= h_count + 12'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			line <= '0;
		end else if (line_end) begin
			line <= frame_end ? 12'd0 : line + 12'd1;
		end
	end

	// ------------------------------------------------------------
	// windows
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			h_window <= 1'b0;
		end else if (h_count == video_pkg::h_sync + video_pkg::h_bporch - 12'd1) begin
			h_window <= 1'b1;
		end else if (h_count == video_pkg::h_sync + video_pkg::h_bporch
				+ video_pkg::h_res - 12'd1) begin
			h_window <= 1'b0;
		end
	end

	// changes only at line boundaries
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			v_window <= 1'b0;
		end else if (line_end) begin
			if (line == video_pkg::v_sync + video_pkg::v_bporch - 12'd1) begin
				v_window <= 1'b1;
			end else if (line == video_pkg::v_sync + video_pkg::v_bporch
					+ video_pkg::v_res - 12'd1) begin
				v_window <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// syncs, positive polarity
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			video_hs <= 1'b0;
		end else if (line_end) begin
			video_hs <= 1'b1;
		end else if (h_count == video_pkg::h_sync - 12'd1) begin
			video_hs <= 1'b0;
		end
	end

	// high while the next line is one of the first v_sync lines
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			video_vs <= 1'b0;
		end else if (line_end) begin
			video_vs <= frame_end || line < video_pkg::v_sync - 12'd1;
		end
	end

endmodule

/* logic/sdram_scheduler.sv */
// fixed 16-clock SDRAM slot schedule, fetches a line pair and splits read words into pixels
`timescale 1ns/100ps

module sdram_scheduler (
	input  logic                     clk,
	input  logic                     reset_n,
	input  video_pkg::t_slot         slot,
	input  logic                     line_end,
	input  video_pkg::t_count        line,
	input  logic                     h_window,
	input  logic                     vram_write_pending,
	input  video_pkg::t_vram_address vram_write_address,
	input  logic [7:0]               vram_write_data,
	input  logic [31:0]              vram_rdata,
	output video_pkg::t_vram_address vram_address,
	output logic                     vram_wr_n,
	output logic                     vram_rd_n,
	output logic                     vram_rfsh_n,
	output logic [7:0]               vram_wdata,
	output logic                     pixel_we,
	output video_pkg::t_pixel_index  pixel_data
);
	logic [7:0]               word_count;
	video_pkg::t_vram_address read_address;
	logic                     is_write_slot;
	logic                     capture;
	logic [31:0]              read_word;
	logic                     read_valid;

	assign is_write_slot = slot == video_pkg::slot_write;

	// read data is back 8 clocks after the read slot
	assign capture = slot == video_pkg::slot_read + 4'd8;

	// ------------------------------------------------------------
	// read address
	// ------------------------------------------------------------
	// one word per 16 clocks, both lines of a pair read one row
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			word_count <= 8'd0;
		end else if (line_end && line[0]) begin
			word_count <= 8'd0;
		end else if (h_window && capture) begin
			word_count <= word_count + 8'd1;
		end
	end

	// 1024 bytes per row
	assign read_address = {2'b00, line[11:1], word_count, 2'b00};

	// ------------------------------------------------------------
	// commands
	// ------------------------------------------------------------
	// write slot becomes refresh when nothing is pending
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			vram_wr_n   <= 1'b1;
			vram_rd_n   <= 1'b1;
			vram_rfsh_n <= 1'b1;
		end else begin
			vram_wr_n   <= !(is_write_slot && vram_write_pending);
			vram_rd_n   <= slot != video_pkg::slot_read;
			vram_rfsh_n <= !(is_write_slot && !vram_write_pending);
		end
	end

	always_ff @(posedge clk) begin
		vram_address <= is_write_slot ? vram_write_address : read_address;
		if (is_write_slot) begin
			vram_wdata <= vram_write_data;
		end
	end

	// ------------------------------------------------------------
	// read word to pixel bytes
	// ------------------------------------------------------------
	// low byte first, shifted on slots 9, 11, 13 and 15
	always_ff @(posedge clk) begin
		if (capture) begin
			read_word <= vram_rdata;
		end else if (read_valid && slot[0]) begin
			read_word <= {8'd0, read_word[31:8]};
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			read_valid <= 1'b0;
		end else if (capture) begin
			read_valid <= 1'b1;
		end else if (read_valid && slot[0]) begin
			// last byte leaves on slot 15
			read_valid <= slot[3:1] != 3'b111;
		end
	end

	// bytes on slots 8, 10, 12 and 14
	assign pixel_we   = read_valid && !slot[0] && h_window;
	assign pixel_data = read_word[7:0];

	a_one_slot_command : assert property (
		@(posedge clk) disable iff (!reset_n) vram_wr_n || vram_rfsh_n
	);

endmodule

/* logic/line_buffer_pair.sv */
// ping-pong line memories, one line pair filled while the previous pair is shown
`timescale 1ns/100ps

module line_buffer_pair (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    line_end,
	input  video_pkg::t_count       line,
	input  logic                    h_window,
	input  video_pkg::t_slot        slot,
	input  logic                    pixel_we,
	input  video_pkg::t_pixel_index pixel_data,
	output video_pkg::t_pixel_index shown_index
);
	video_pkg::t_line_address write_address;
	video_pkg::t_line_address read_address;
	video_pkg::t_line_address address_0;
	video_pkg::t_line_address address_1;
	video_pkg::t_pixel_index  rdata_0;
	video_pkg::t_pixel_index  rdata_1;
	logic                     fill_1;

	// 640 bytes over both lines of a pair
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			write_address <= '0;
		end else if (line_end && line[0]) begin
			write_address <= '0;
		end else if (pixel_we) begin
			write_address <= write_address + 10'd1;
		end
	end

	// steps every second clock, three clocks ahead of the colour
	// so slot 15 before the window already addresses pixel 1
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			read_address <= '0;
		end else if (!h_window && slot == 4'd12) begin
			read_address <= '0;
		end else if (!slot[0]) begin
			read_address <= read_address + 10'd1;
		end
	end

	// ------------------------------------------------------------
	// buffer select, swaps every two lines
	// ------------------------------------------------------------
	assign fill_1    = line[1];
	assign address_0 = fill_1 ? read_address : write_address;
	assign address_1 = fill_1 ? write_address : read_address;

	sp_ram #(.t_data(video_pkg::t_pixel_index), .depth(1024)) i_buffer_0 (
		.clk     (clk),
		.address (address_0),
		.we      (pixel_we && !fill_1),
		.wdata   (pixel_data),
		.rdata   (rdata_0)
	);

	sp_ram #(.t_data(video_pkg::t_pixel_index), .depth(1024)) i_buffer_1 (
		.clk     (clk),
		.address (address_1),
		.we      (pixel_we && fill_1),
		.wdata   (pixel_data),
		.rdata   (rdata_1)
	);

	assign shown_index = fill_1 ? rdata_0 : rdata_1;

endmodule

/* logic/pixel_output.sv */
// palette lookup shared between CPU writes and display reads, colour register and blanking
`timescale 1ns/100ps

module pixel_output (
	input  logic                    clk,
	input  logic                    reset_n,
	input  video_pkg::t_slot        slot,
	input  logic                    h_window,
	input  logic                    v_window,
	input  video_pkg::t_pixel_index shown_index,
	input  logic                    palette_pending,
	input  video_pkg::t_pixel_index palette_index,
	input  video_pkg::t_rgb         palette_rgb,
	output logic                    video_de,
	output logic [7:0]              video_r,
	output logic [7:0]              video_g,
	output logic [7:0]              video_b
);
	video_pkg::t_pixel_index lookup_index;
	video_pkg::t_rgb         lookup_rgb;
	video_pkg::t_rgb         colour;

	// odd slots belong to the CPU, even slots to the display
	assign lookup_index = slot[0] ? palette_index : shown_index;

	sp_ram #(.t_data(video_pkg::t_rgb), .depth(256)) i_palette (
		.clk     (clk),
		.address (lookup_index),
		.we      (palette_pending && slot[0]),
		.wdata   (palette_rgb),
		.rdata   (lookup_rgb)
	);

	// even-slot read is on the ram output during the odd slot
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			colour <= '0;
		end else if (slot[0]) begin
			colour <= lookup_rgb;
		end
	end

	assign video_de = h_window && v_window;
	assign video_r  = video_de ? colour.r : 8'd0;
	assign video_g  = video_de ? colour.g : 8'd0;
	assign video_b  = video_de ? colour.b : 8'd0;

endmodule

/* logic/video_top.sv */
// indexed-colour 720p video controller with CPU ports and an SDRAM frame buffer
`timescale 1ns/100ps

module video_top (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     iorq_n,
	input  logic [7:0]               address,
	input  logic                     wr_n,
	input  logic [7:0]               wdata,
	input  logic [31:0]              vram_rdata,
	output video_pkg::t_vram_address vram_address,
	output logic                     vram_wr_n,
	output logic                     vram_rd_n,
	output logic                     vram_rfsh_n,
	output logic [7:0]               vram_wdata,
	output logic                     video_de,
	output logic                     video_hs,
	output logic                     video_vs,
	output logic [7:0]               video_r,
	output logic [7:0]               video_g,
	output logic [7:0]               video_b
);
	// ------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------
	video_pkg::t_slot         slot;
	logic                     line_end;
	video_pkg::t_count        line;
	logic                     h_window;
	logic                     v_window;
	logic                     palette_pending;
	video_pkg::t_pixel_index  palette_index;
	video_pkg::t_rgb          palette_rgb;
	logic                     vram_write_pending;
	video_pkg::t_vram_address vram_write_address;
	logic [7:0]               vram_write_data;
	logic                     pixel_we;
	video_pkg::t_pixel_index  pixel_data;
	video_pkg::t_pixel_index  shown_index;

	cpu_registers i_cpu_registers (
		.clk                (clk),
		.reset_n            (reset_n),
		.iorq_n             (iorq_n),
		.address            (address),
		.wr_n               (wr_n),
		.wdata              (wdata),
		.slot               (slot),
		.palette_pending    (palette_pending),
		.palette_index      (palette_index),
		.palette_rgb        (palette_rgb),
		.vram_write_pending (vram_write_pending),
		.vram_write_address (vram_write_address),
		.vram_write_data    (vram_write_data)
	);

	display_timing i_display_timing (
		.clk      (clk),
		.reset_n  (reset_n),
		.slot     (slot),
		.line_end (line_end),
		.line     (line),
		.h_window (h_window),
		.v_window (v_window),
		.video_hs (video_hs),
		.video_vs (video_vs)
	);

	sdram_scheduler i_sdram_scheduler (
		.clk                (clk),
		.reset_n            (reset_n),
		.slot               (slot),
		.line_end           (line_end),
		.line               (line),
		.h_window           (h_window),
		.vram_write_pending (vram_write_pending),
		.vram_write_address (vram_write_address),
		.vram_write_data    (vram_write_data),
		.vram_rdata         (vram_rdata),
		.vram_address       (vram_address),
		.vram_wr_n          (vram_wr_n),
		.vram_rd_n          (vram_rd_n),
		.vram_rfsh_n        (vram_rfsh_n),
		.vram_wdata         (vram_wdata),
		.pixel_we           (pixel_we),
		.pixel_data         (pixel_data)
	);

	line_buffer_pair i_line_buffer_pair (
		.clk         (clk),
		.reset_n     (reset_n),
		.line_end    (line_end),
		.line        (line),
		.h_window    (h_window),
		.slot        (slot),
		.pixel_we    (pixel_we),
		.pixel_data  (pixel_data),
		.shown_index (shown_index)
	);

	pixel_output i_pixel_output (
		.clk             (clk),
		.reset_n         (reset_n),
		.slot            (slot),
		.h_window        (h_window),
		.v_window        (v_window),
		.shown_index     (shown_index),
		.palette_pending (palette_pending),
		.palette_index   (palette_index),
		.palette_rgb     (palette_rgb),
		.video_de        (video_de),
		.video_r         (video_r),
		.video_g         (video_g),
		.video_b         (video_b)
	);

endmodule

/* test/tb_clock.sv */
// testbench clock and reset source, 40 ns clock with reset held low for eight cycles
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic reset_n
);
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// release just after the eighth rising edge
	initial begin
		reset_n = 1'b0;
		repeat (8) @(posedge clk);
		#1 reset_n = 1'b1;
	end

endmodule

/* test/tb_video_top.sv */
// testbench for the video controller, CPU writes from the tests file, VRAM model and output checks
`timescale 1ns/100ps

module tb_video_top;

	// one frame plus the lines checked in the second frame, with margin
	localparam int cycle_limit = (750 + 30) * 1650;

	logic        clk;
	logic        reset_n;
	logic        iorq_n;
	logic [7:0]  address;
	logic        wr_n;
	logic [7:0]  wdata;
	logic [31:0] vram_rdata;
	logic [22:0] vram_address;
	logic        vram_wr_n;
	logic        vram_rd_n;
	logic        vram_rfsh_n;
	logic [7:0]  vram_wdata;
	logic        video_de;
	logic        video_hs;
	logic        video_vs;
	logic [7:0]  video_r;
	logic [7:0]  video_g;
	logic [7:0]  video_b;

	// ------------------------------------------------------------
	// checker state
	// ------------------------------------------------------------
	integer      seed;
	logic [23:0] pal_model [256];
	logic [22:0] write_addrs [$];
	logic [7:0]  write_bytes [$];
	int          cycles;
	int          error_count;
	int          h_pos;
	int          line_no;
	int          lines_seen;
	int          frame_no;
	int          de_pos;
	int          pixel_index;
	logic        hs_q;
	logic        de_q;
	logic        de_seen;
	logic        after_reset;
	logic        first_frame_done;
	logic        rewrite_done;

	tb_clock i_tb_clock (
		.clk     (clk),
		.reset_n (reset_n)
	);

	video_top i_video_top (
		.clk          (clk),
		.reset_n      (reset_n),
		.iorq_n       (iorq_n),
		.address      (address),
		.wr_n         (wr_n),
		.wdata        (wdata),
		.vram_rdata   (vram_rdata),
		.vram_address (vram_address),
		.vram_wr_n    (vram_wr_n),
		.vram_rd_n    (vram_rd_n),
		.vram_rfsh_n  (vram_rfsh_n),
		.vram_wdata   (vram_wdata),
		.video_de     (video_de),
		.video_hs     (video_hs),
		.video_vs     (video_vs),
		.video_r      (video_r),
		.video_g      (video_g),
		.video_b      (video_b)
	);

	task report_error(input string text);
		error_count = error_count + 1;
		$display("%s", text);
		$display("** FAIL **");
		$fatal(1, "run stopped at first error");
	endtask

	// one Z80 style I/O write, wr_n back high on the strobe clock
	task cpu_write(input logic [7:0] port, input logic [7:0] value);
		@(posedge clk);
		#1;
		// data bytes start on the clock after a read command so the write slot is ahead
		if (port == video_pkg::port_vram_data) begin
			while (vram_rd_n) begin
				@(posedge clk);
				#1;
			end
		end
		iorq_n  = 1'b0;
		wr_n    = 1'b0;
		address = port;
		wdata   = value;
		@(posedge clk);
		#1;
		iorq_n = 1'b1;
		wr_n   = 1'b1;
	endtask

	task write_palette_entry(input logic [7:0] index, input logic [23:0] rgb);
		cpu_write(video_pkg::port_palette_index, index);
		cpu_write(video_pkg::port_palette_data, rgb[23:16]);
		cpu_write(video_pkg::port_palette_data, rgb[15:8]);
		cpu_write(video_pkg::port_palette_data, rgb[7:0]);
		pal_model[index] = rgb;
	endtask

	// exactly one write command, with the expected address and byte
	task check_vram_write(input logic [22:0] exp_address, input logic [7:0] exp_data);
		int          waited;
		logic [22:0] got_address;
		logic [7:0]  got_data;
		waited = 0;
		while (write_addrs.size() == 0 && waited < 64) begin
			@(posedge clk);
			waited = waited + 1;
		end
		assert (write_addrs.size() != 0)
			else report_error("no VRAM write command followed the data byte write");
		got_address = write_addrs.pop_front();
		got_data    = write_bytes.pop_front();
		assert (got_address == exp_address) else report_error($sformatf(
			"[FAIL] %0t vram_address expected %06h got %06h", $time, exp_address, got_address));
		assert (got_data == exp_data) else report_error($sformatf(
			"[FAIL] %0t vram_wdata expected %02h got %02h", $time, exp_data, got_data));
		repeat (48) @(posedge clk);
		assert (write_addrs.size() == 0)
			else report_error("more than one VRAM write command for a single data byte");
	endtask

	task check_reset_levels;
		assert ({video_hs, video_vs, video_de, vram_wr_n, vram_rd_n, vram_rfsh_n} == 6'b000111)
			else report_error($sformatf("[FAIL] %0t {hs,vs,de,wr_n,rd_n,rfsh_n} expected %b got %b",
				$time, 6'b000111,
				{video_hs, video_vs, video_de, vram_wr_n, vram_rd_n, vram_rfsh_n}));
		assert ({video_r, video_g, video_b} == 24'd0) else report_error($sformatf(
			"[FAIL] %0t video_rgb expected %06h got %06h", $time, 24'd0,
			{video_r, video_g, video_b}));
	endtask

	// ------------------------------------------------------------
	// VRAM model
	// ------------------------------------------------------------
	// all four bytes of word A hold low 8 bits of A/1024 + A/4
	always @(posedge clk) begin
		#1;
		if (!vram_rd_n) begin
			vram_rdata = {4{8'(vram_address / 1024 + vram_address / 4)}};
		end
	end

	// ------------------------------------------------------------
	// output monitor, sampled mid-cycle
	// ------------------------------------------------------------
	always @(negedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
		if (!reset_n) begin
			check_reset_levels();
			after_reset = 1'b1;
		end else if (after_reset) begin
			// one clock after release, still at reset levels
			check_reset_levels();
			after_reset = 1'b0;
		end else begin
			// line start at hs rise
			if (video_hs && !hs_q) begin
				if (lines_seen > 0) begin
					assert (h_pos + 1 == 1650) else report_error($sformatf(
						"[FAIL] %0t line length expected %0d got %0d", $time, 1650, h_pos + 1));
				end
				h_pos = 0;
				if (line_no == 749) begin
					line_no  = 0;
					frame_no = frame_no + 1;
				end else begin
					line_no = line_no + 1;
				end
				lines_seen = lines_seen + 1;
				assert (video_vs == (line_no < 5)) else report_error($sformatf(
					"[FAIL] %0t video_vs expected %b got %b", $time, line_no < 5, video_vs));
			end else begin
				h_pos = h_pos + 1;
			end
			if (!video_hs && hs_q) begin
				assert (h_pos == 40) else report_error($sformatf(
					"[FAIL] %0t hs width expected %0d got %0d", $time, 40, h_pos));
			end

			// slot 0 is h_pos 260, commands come one clock after slots 15 and 7
			if (lines_seen > 0) begin
				assert (vram_rd_n == (h_pos % 16 != 4)) else report_error($sformatf(
					"[FAIL] %0t vram_rd_n expected %b got %b", $time, h_pos % 16 != 4, vram_rd_n));
				if (h_pos % 16 == 12) begin
					assert (vram_wr_n ^ vram_rfsh_n) else report_error($sformatf(
						"[FAIL] %0t vram_wr_n^vram_rfsh_n expected 1 got %b", $time,
						vram_wr_n ^ vram_rfsh_n));
				end else begin
					assert (vram_wr_n && vram_rfsh_n) else report_error($sformatf(
						"[FAIL] %0t {vram_wr_n,vram_rfsh_n} expected 11 got %b%b", $time,
						vram_wr_n, vram_rfsh_n));
				end
			end
			if (!vram_rd_n) begin
				assert (vram_address[1:0] == 2'b00) else report_error($sformatf(
					"[FAIL] %0t vram_address[1:0] expected %b got %b", $time, 2'b00,
					vram_address[1:0]));
			end
			if (!vram_wr_n) begin
				write_addrs.push_back(vram_address);
				write_bytes.push_back(vram_wdata);
			end

			// active area
			if (video_de && !de_q) begin
				assert (h_pos == 260) else report_error($sformatf(
					"[FAIL] %0t de start expected %0d got %0d", $time, 260, h_pos));
				assert (line_no >= 25 && line_no <= 744 && (de_seen || line_no == 25))
					else report_error($sformatf("[FAIL] %0t de line expected %s got %0d",
					$time, de_seen ? "25..744" : "25", line_no));
				de_seen = 1'b1;
				de_pos  = 0;
			end
			if (video_de) begin
				// line pair shows the row fetched during the previous pair
				if ((frame_no == 0 && line_no < 29) || (frame_no == 1 && line_no == 25)) begin
					pixel_index = (line_no / 2 - 1 + de_pos / 8) % 256;
					assert ({video_r, video_g, video_b} == pal_model[pixel_index])
						else report_error($sformatf("[FAIL] %0t video_rgb expected %06h got %06h",
						$time, pal_model[pixel_index], {video_r, video_g, video_b}));
				end
				de_pos = de_pos + 1;
			end
			if (!video_de && de_q) begin
				assert (de_pos == 1280) else report_error($sformatf(
					"[FAIL] %0t de width expected %0d got %0d", $time, 1280, de_pos));
				if (frame_no == 0 && line_no == 28) begin
					first_frame_done = 1'b1;
				end
				if (frame_no == 1 && line_no == 25) begin
					rewrite_done = 1'b1;
				end
			end
		end
		hs_q = video_hs;
		de_q = video_de;
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin
		int          fd;
		int          fields;
		string       text;
		logic [7:0]  kind;
		logic [22:0] value_a;
		logic [7:0]  value_b;
		logic [23:0] new_rgb;
		iorq_n           = 1'b1;
		wr_n             = 1'b1;
		address          = 8'h00;
		wdata            = 8'h00;
		vram_rdata       = 32'd0;
		seed             = 32'h5601_8634;
		cycles           = 0;
		error_count      = 0;
		h_pos            = 0;
		line_no          = 0;
		lines_seen       = 0;
		frame_no         = 0;
		de_pos           = 0;
		hs_q             = 1'b0;
		de_q             = 1'b0;
		de_seen          = 1'b0;
		after_reset      = 1'b0;
		first_frame_done = 1'b0;
		rewrite_done     = 1'b0;
		for (int i = 0; i < 256; i++) begin
			pal_model[i] = 24'd0;
		end
		wait (reset_n);

		// entries 0 to 199, one index write then auto increment
		cpu_write(video_pkg::port_palette_index, 8'd0);
		for (int i = 0; i < 200; i++) begin
			new_rgb = 24'($random(seed));
			cpu_write(video_pkg::port_palette_data, new_rgb[23:16]);
			cpu_write(video_pkg::port_palette_data, new_rgb[15:8]);
			cpu_write(video_pkg::port_palette_data, new_rgb[7:0]);
			pal_model[i] = new_rgb;
		end

		// port writes and expected write commands
		fd = $fopen("test/video_tests.txt", "r");
		assert (fd != 0) else report_error("cannot open test/video_tests.txt");
		while (!$feof(fd)) begin
			text = "";
			void'($fgets(text, fd));
			fields = $sscanf(text, "%c %h %h", kind, value_a, value_b);
			if (fields == 3 && kind == "w") begin
				cpu_write(value_a[7:0], value_b);
			end else if (fields == 3 && kind == "e") begin
				check_vram_write(value_a, value_b);
			end
		end
		$fclose(fd);

		// new colour for entry 11 between frames, seen at the start of the next frame
		wait (first_frame_done && frame_no == 1);
		new_rgb = 24'($random(seed));
		if (new_rgb == pal_model[11]) begin
			new_rgb = ~new_rgb;
		end
		write_palette_entry(8'd11, new_rgb);
		wait (rewrite_done);

		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* test/video_tests.txt */
# w <port> <value>      CPU I/O port write, hex
# e <address> <data>    expected VRAM write command, hex
w 22 10
w 22 32
w 22 04
w 23 5a
e 043210 5a
w 23 a7
e 043211 a7
w 22 ff
w 22 ff
w 22 7f
w 23 01
e 7fffff 01
w 23 c3
e 000000 c3
w 22 00
w 22 80
w 22 01
w 23 3c
e 018000 3c

/* vlog.f */
logic/video_pkg.sv
logic/sp_ram.sv
logic/cpu_registers.sv
logic/display_timing.sv
logic/sdram_scheduler.sv
logic/line_buffer_pair.sv
logic/pixel_output.sv
logic/video_top.sv
test/tb_clock.sv
test/tb_video_top.sv
